// File: conv2d.f
+incdir+hw
hw/conv2d_pkg.sv
hw/fifo.sv
hw/conv2d_mem_if.sv
hw/conv2d_compute.sv
hw/conv2d.sv
verif/conv2d_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the conv2d testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module conv2d_tb -f conv2d.f -o conv2d_sim > build.log 2>&1 \
    && ./obj_dir/conv2d_sim > sim.log 2>&1 \
    || echo "build or simulation returned an error status, see build.log and sim.log"

cat sim.log 2>/dev/null

grep -qx "Regression passed" sim.log \
    && echo "simulation log reports success" \
    || { echo "simulation log does not report success"; exit 1; }

// File: verif/conv2d_tb.sv
`include "conv2d_settings.svh"

module conv2d_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import conv2d_pkg::*;

    localparam int WT_DIM    = `CONV_WT_DIM;
    localparam int WT_SIZE   = WT_DIM * WT_DIM;
    localparam int HALF      = WT_DIM / 2;
    localparam int MEM_AW    = 12;
    localparam int MEM_WORDS = 1 << MEM_AW;
    // output pixels summed over every job of the run
    localparam int TOTAL_PIXELS    = 16 + 36 + 1 + 25 + 16 + 25;
    localparam int CYCLES_PER_PIX  = 64 * 4;
    localparam int WATCHDOG_CYCLES = CYCLES_PER_PIX * TOTAL_PIXELS + 1000;

    logic                    clk;
    logic                    rst;
    logic                    start;
    logic                    idle;
    logic [31:0]             fm_dim;
    logic [31:0]             wt_offset;
    logic [31:0]             ifm_offset;
    logic [31:0]             ofm_offset;
    logic [`CONV_AWIDTH-1:0] req_read_addr;
    logic                    req_read_addr_valid;
    logic                    req_read_addr_ready;
    logic [`CONV_DWIDTH-1:0] resp_read_data;
    logic                    resp_read_data_valid;
    logic                    resp_read_data_ready;
    mem_wr_req_t             req_write;
    logic                    req_write_valid;
    logic                    req_write_ready;
    logic                    resp_write_status;
    logic                    resp_write_status_valid;
    logic                    resp_write_status_ready;

    logic [31:0] mem [MEM_WORDS];
    bit          written [MEM_WORDS];
    logic [31:0] rd_data_q [$];
    int          rd_due_q [$];
    int          status_pending;
    int          cycle;
    bit          stalls_on;
    int          seed;
    int          wt_reads;
    int          ifm_reads;
    int          writes;
    int          errors;
    int          checks;
    int          tests;
    int          err_mark;

    conv2d uut (
        .clk                     (clk),
        .rst                     (rst),
        .start                   (start),
        .idle                    (idle),
        .fm_dim                  (fm_dim),
        .wt_offset               (wt_offset),
        .ifm_offset              (ifm_offset),
        .ofm_offset              (ofm_offset),
        .req_read_addr           (req_read_addr),
        .req_read_addr_valid     (req_read_addr_valid),
        .req_read_addr_ready     (req_read_addr_ready),
        .resp_read_data          (resp_read_data),
        .resp_read_data_valid    (resp_read_data_valid),
        .resp_read_data_ready    (resp_read_data_ready),
        .req_write               (req_write),
        .req_write_valid         (req_write_valid),
        .req_write_ready         (req_write_ready),
        .resp_write_status       (resp_write_status),
        .resp_write_status_valid (resp_write_status_valid),
        .resp_write_status_ready (resp_write_status_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic bit coin();
        int r;
        r = $random(seed);
        return r[0];
    endfunction

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            $display("MISMATCH at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            $display("ERROR at %0t ns: %s", $time, what);
            errors++;
        end
    endtask

    task automatic note_read(input logic [31:0] addr);
        bit in_wt;
        bit in_ifm;
        in_wt  = addr >= wt_offset && addr < wt_offset + 32'(WT_SIZE);
        in_ifm = addr >= ifm_offset && addr < ifm_offset + fm_dim * fm_dim;
        if (in_wt) wt_reads++;
        if (in_ifm) ifm_reads++;
        check_true(in_wt || in_ifm,
                   $sformatf("read at address %0h lies outside the weight and input regions", addr));
    endtask

    task automatic note_write(input mem_wr_req_t wr);
        logic [31:0] rel;
        rel = wr.addr - ofm_offset;
        check_true(rel < fm_dim * fm_dim,
                   $sformatf("write to address %0h lies outside the output region", wr.addr));
        check_true(!written[MEM_AW'(wr.addr)],
                   $sformatf("output address %0h was written twice", wr.addr));
        written[MEM_AW'(wr.addr)] = 1'b1;
        mem[MEM_AW'(wr.addr)] = wr.data;
        writes++;
    endtask

    // memory model drives its inputs on the falling edge and reads back
    // the handshakes that the next rising edge completes 1 ns later
    initial begin : memory_model
        int r;
        req_read_addr_ready     = 1'b0;
        resp_read_data          = '0;
        resp_read_data_valid    = 1'b0;
        req_write_ready         = 1'b0;
        resp_write_status       = 1'b0;
        resp_write_status_valid = 1'b0;
        status_pending          = 0;
        cycle                   = 0;
        forever begin
            @(negedge clk);
            if (rst) begin
                req_read_addr_ready     = 1'b0;
                resp_read_data_valid    = 1'b0;
                req_write_ready         = 1'b0;
                resp_write_status_valid = 1'b0;
            end else begin
                req_read_addr_ready  = !stalls_on || coin();
                req_write_ready      = !stalls_on || coin();
                resp_read_data_valid = 1'b0;
                resp_read_data       = '0;
                // responses leave in request order once their latency is over
                if (rd_data_q.size() != 0) begin
                    if (rd_due_q[0] <= cycle) begin
                        resp_read_data_valid = 1'b1;
                        resp_read_data       = rd_data_q[0];
                    end
                end
                resp_write_status_valid = status_pending != 0 && (!stalls_on || coin());
                resp_write_status       = 1'b1;
                #1;
                if (resp_read_data_valid && resp_read_data_ready) begin
                    void'(rd_data_q.pop_front());
                    void'(rd_due_q.pop_front());
                end
                if (req_read_addr_valid && req_read_addr_ready) begin
                    note_read(req_read_addr);
                    r = $random(seed);
                    rd_data_q.push_back(mem[MEM_AW'(req_read_addr)]);
                    rd_due_q.push_back(cycle + 1 + (stalls_on ? int'(r[1:0]) : 0));
                end
                if (resp_write_status_valid && resp_write_status_ready) status_pending--;
                if (req_write_valid && req_write_ready) begin
                    note_write(req_write);
                    status_pending++;
                end
            end
            cycle++;
        end
    end

    // plain convolution over the memory array where border cells count as zero
    function automatic logic [31:0] ref_pixel(input int dim, input int x, input int y,
                                             input logic [31:0] wt_base,
                                             input logic [31:0] ifm_base);
        logic [31:0] sum;
        logic [31:0] pix;
        logic [31:0] wt;
        int          ix;
        int          iy;
        sum = '0;
        for (int m = 0; m < WT_DIM; m++) begin
            for (int n = 0; n < WT_DIM; n++) begin
                iy = y + m - HALF;
                ix = x + n - HALF;
                if (ix >= 0 && iy >= 0 && ix < dim && iy < dim) begin
                    pix = mem[MEM_AW'(ifm_base + 32'(iy * dim + ix))];
                    wt  = mem[MEM_AW'(wt_base + 32'(m * WT_DIM + n))];
                    sum = sum + pix * wt;
                end
            end
        end
        return sum;
    endfunction

    // in-map elements counted per axis and squared since rows and columns are independent
    function automatic int count_map_reads(input int dim);
        int axis;
        axis = 0;
        for (int x = 0; x < dim; x++) begin
            for (int n = 0; n < WT_DIM; n++) begin
                if (x + n - HALF >= 0 && x + n - HALF < dim) axis++;
            end
        end
        return axis * axis;
    endfunction

    task automatic fill_random(input logic [31:0] base, input int count);
        for (int k = 0; k < count; k++) begin
            mem[MEM_AW'(base + 32'(k))] = 32'($random(seed));
        end
    endtask

    task automatic run_job(input int dim, input logic [31:0] wt_base,
                           input logic [31:0] ifm_base, input logic [31:0] ofm_base);
        logic [31:0] expected [$];
        int          waited;
        int          limit;
        for (int y = 0; y < dim; y++) begin
            for (int x = 0; x < dim; x++) begin
                expected.push_back(ref_pixel(dim, x, y, wt_base, ifm_base));
            end
        end
        foreach (written[a]) written[a] = 1'b0;
        wt_reads  = 0;
        ifm_reads = 0;
        writes    = 0;
        @(negedge clk);
        fm_dim     = 32'(dim);
        wt_offset  = wt_base;
        ifm_offset = ifm_base;
        ofm_offset = ofm_base;
        start      = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_true(!idle, "idle stayed high after start");
        limit  = CYCLES_PER_PIX * dim * dim + 100;
        waited = 0;
        while (!idle && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        check_true(idle, $sformatf("job on a %0dx%0d map did not finish in %0d cycles",
                                   dim, dim, limit));
        check_true(rd_data_q.size() == 0 && status_pending == 0,
                   "read data or write status still outstanding after the job");
        for (int i = 0; i < dim * dim; i++) begin
            check_word($sformatf("ofm[%0d]", i), mem[MEM_AW'(ofm_base + 32'(i))], expected[i]);
        end
    endtask

    task automatic check_traffic(input int dim);
        check_word("weight read count", 32'(wt_reads), 32'(WT_SIZE));
        check_word("input read count", 32'(ifm_reads), 32'(count_map_reads(dim)));
        check_word("write count", 32'(writes), 32'(dim * dim));
    endtask

    task automatic test_reset_state();
        repeat (8) begin
            @(negedge clk);
            check_true(idle, "idle low although no job was started");
            check_true(!req_read_addr_valid && !req_write_valid,
                       "request valid high before the first start");
        end
    endtask

    task automatic test_known_4x4();
        stalls_on = 1'b0;
        // kernel runs from -4 up to 4
        for (int k = 0; k < WT_SIZE; k++) begin
            mem[MEM_AW'(32'h100 + 32'(k))] = 32'(k - WT_SIZE / 2);
        end
        for (int i = 0; i < 16; i++) begin
            mem[MEM_AW'(32'h200 + 32'(i))] = 32'(3 * i + 1);
        end
        run_job(4, 32'h100, 32'h200, 32'h280);
    endtask

    task automatic test_random_6x6();
        stalls_on = 1'b1;
        fill_random(32'h400, WT_SIZE);
        fill_random(32'h410, 36);
        run_job(6, 32'h400, 32'h410, 32'h480);
        check_traffic(6);
        stalls_on = 1'b0;
    endtask

    task automatic test_single_pixel();
        logic [31:0] centre;
        logic [31:0] pix;
        fill_random(32'h500, WT_SIZE);
        fill_random(32'h510, 1);
        centre = mem[MEM_AW'(32'h500 + 32'(WT_SIZE / 2))];
        pix    = mem[MEM_AW'(32'h510)];
        run_job(1, 32'h500, 32'h510, 32'h520);
        check_word("ofm[0]", mem[MEM_AW'(32'h520)], centre * pix);
        check_word("input read count", 32'(ifm_reads), 32'd1);
    endtask

    // regions packed end to end so a stray read lands in a neighbour
    task automatic test_address_range();
        stalls_on = 1'b1;
        fill_random(32'h600, WT_SIZE);
        fill_random(32'h600 + 32'(WT_SIZE), 25);
        run_job(5, 32'h600, 32'h600 + 32'(WT_SIZE), 32'h600 + 32'(WT_SIZE + 25));
        check_traffic(5);
        stalls_on = 1'b0;
    endtask

    task automatic test_back_to_back();
        fill_random(32'h700, WT_SIZE);
        fill_random(32'h710, 16);
        fill_random(32'h800, WT_SIZE);
        fill_random(32'h810, 25);
        run_job(4, 32'h700, 32'h710, 32'h740);
        check_traffic(4);
        stalls_on = 1'b1;
        run_job(5, 32'h800, 32'h810, 32'h840);
        check_traffic(5);
        stalls_on = 1'b0;
    endtask

    task automatic report_test(input string name);
        tests++;
        $display("test %s finished with %0d errors", name, errors - err_mark);
    endtask

    initial begin
        rst        = 1'b1;
        start      = 1'b0;
        fm_dim     = '0;
        wt_offset  = '0;
        ifm_offset = '0;
        ofm_offset = '0;
        stalls_on  = 1'b0;
        seed       = 32'h9ec1_0c89;
        errors     = 0;
        checks     = 0;
        tests      = 0;
        // background pattern mixes every address bit
        for (int a = 0; a < MEM_WORDS; a++) begin
            mem[a] = (32'(a) * 32'h9e37_79b1) ^ 32'h5a5a_0000;
        end
        repeat (16) @(negedge clk);
        rst = 1'b0;

        err_mark = errors;
        test_reset_state();
        report_test("reset_state");
        err_mark = errors;
        test_known_4x4();
        report_test("known_4x4");
        err_mark = errors;
        test_random_6x6();
        report_test("random_6x6");
        err_mark = errors;
        test_single_pixel();
        report_test("single_pixel");
        err_mark = errors;
        test_address_range();
        report_test("address_range");
        err_mark = errors;
        test_back_to_back();
        report_test("back_to_back");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog: run still busy after %0d cycles", WATCHDOG_CYCLES);
        $display("Regression failed");
        $finish;
    end

endmodule

// File: hw/conv2d.sv
`include "conv2d_settings.svh"

module conv2d (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        start,
    output logic                        idle,
    input  logic [31:0]                 fm_dim,
    input  logic [31:0]                 wt_offset,
    input  logic [31:0]                 ifm_offset,
    input  logic [31:0]                 ofm_offset,

    output logic [`CONV_AWIDTH-1:0]     req_read_addr,
    output logic                        req_read_addr_valid,
    input  logic                        req_read_addr_ready,

    input  logic [`CONV_DWIDTH-1:0]     resp_read_data,
    input  logic                        resp_read_data_valid,
    output logic                        resp_read_data_ready,

    output conv2d_pkg::mem_wr_req_t     req_write,
    output logic                        req_write_valid,
    input  logic                        req_write_ready,

    input  logic                        resp_write_status,
    input  logic                        resp_write_status_valid,
    output logic                        resp_write_status_ready
);
    import conv2d_pkg::*;

    elem_tag_t                tag_enq;
    logic                     tag_enq_valid;
    logic                     tag_enq_ready;
    elem_tag_t                tag_deq;
    logic                     tag_deq_valid;
    logic                     tag_deq_ready;
    logic [`CONV_DWIDTH-1:0]  ofm_data;
    logic                     ofm_valid;
    logic                     ofm_ready;

    conv2d_mem_if mem_if (
        .clk                     (clk),
        .rst                     (rst),
        .start                   (start),
        .idle                    (idle),
        .fm_dim                  (fm_dim),
        .wt_offset               (wt_offset),
        .ifm_offset              (ifm_offset),
        .ofm_offset              (ofm_offset),
        .req_read_addr           (req_read_addr),
        .req_read_addr_valid     (req_read_addr_valid),
        .req_read_addr_ready     (req_read_addr_ready),
        .tag                     (tag_enq),
        .tag_valid               (tag_enq_valid),
        .tag_ready               (tag_enq_ready),
        .ofm_data                (ofm_data),
        .ofm_valid               (ofm_valid),
        .ofm_ready               (ofm_ready),
        .req_write               (req_write),
        .req_write_valid         (req_write_valid),
        .req_write_ready         (req_write_ready),
        .resp_write_status       (resp_write_status),
        .resp_write_status_valid (resp_write_status_valid),
        .resp_write_status_ready (resp_write_status_ready)
    );

    // tags line up issued and skipped elements with the in-order read data
    fifo #(
        .WIDTH    ($bits(elem_tag_t)),
        .LOGDEPTH (`CONV_FIFO_LOGDEPTH)
    ) tag_fifo (
        .clk       (clk),
        .rst       (rst),
        .enq_valid (tag_enq_valid),
        .enq_data  (tag_enq),
        .enq_ready (tag_enq_ready),
        .deq_valid (tag_deq_valid),
        .deq_data  (tag_deq),
        .deq_ready (tag_deq_ready)
    );

    conv2d_compute compute (
        .clk                  (clk),
        .rst                  (rst),
        .tag                  (tag_deq),
        .tag_valid            (tag_deq_valid),
        .tag_ready            (tag_deq_ready),
        .resp_read_data       (resp_read_data),
        .resp_read_data_valid (resp_read_data_valid),
        .resp_read_data_ready (resp_read_data_ready),
        .ofm_data             (ofm_data),
        .ofm_valid            (ofm_valid),
        .ofm_ready            (ofm_ready)
    );

endmodule

// File: hw/conv2d_compute.sv
`include "conv2d_settings.svh"

module conv2d_compute (
    input  logic                    clk,
    input  logic                    rst,

    input  conv2d_pkg::elem_tag_t   tag,
    input  logic                    tag_valid,
    output logic                    tag_ready,

    input  logic [`CONV_DWIDTH-1:0] resp_read_data,
    input  logic                    resp_read_data_valid,
    output logic                    resp_read_data_ready,

    output logic [`CONV_DWIDTH-1:0] ofm_data,
    output logic                    ofm_valid,
    input  logic                    ofm_ready
);

    localparam int WT_SIZE = `CONV_WT_DIM * `CONV_WT_DIM;
    localparam int IDX_W   = $clog2(WT_SIZE + 1);

    logic signed [`CONV_DWIDTH-1:0] wt [WT_SIZE];
    logic [IDX_W-1:0]               load_idx;
    logic [IDX_W-1:0]               win_idx;
    logic signed [`CONV_DWIDTH-1:0] acc;
    logic signed [`CONV_DWIDTH-1:0] elem;
    logic signed [`CONV_DWIDTH-1:0] product;
    logic signed [`CONV_DWIDTH-1:0] acc_sum;
    logic                           pop;
    logic                           pop_wt;
    logic                           pop_win;

    // a non-halo tag leaves together with its read data
    assign resp_read_data_ready = tag_valid & ~tag.halo;
    assign tag_ready            = tag.halo | resp_read_data_valid;

    assign pop     = tag_valid & tag_ready;
    assign pop_wt  = pop & tag.is_weight;
    assign pop_win = pop & ~tag.is_weight;

    // halo cells contribute zero and products wrap at the data width
    assign elem    = tag.halo ? '0 : $signed(resp_read_data);
    assign product = elem * wt[win_idx];
    assign acc_sum = acc + product;

    always_ff @(posedge clk) begin
        if (pop_wt) begin
            wt[load_idx] <= $signed(resp_read_data);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            load_idx  <= '0;
            win_idx   <= '0;
            acc       <= '0;
            ofm_valid <= 1'b0;
        end else begin
            if (pop_wt) begin
                load_idx <= tag.last ? '0 : load_idx + 1'b1;
            end
            if (pop_win) begin
                win_idx <= tag.last ? '0 : win_idx + 1'b1;
                acc     <= tag.last ? '0 : acc_sum;
            end
            if (pop_win && tag.last) begin
                ofm_valid <= 1'b1;
            end else if (ofm_ready) begin
                ofm_valid <= 1'b0;
            end
        end
    end

    // result register holds until the address generator takes it
    always_ff @(posedge clk) begin
        if (pop_win && tag.last) begin
            ofm_data <= acc_sum;
        end
    end

    // a response can only follow a request whose tag was already pushed
    a_data_has_tag: assert property (@(posedge clk) disable iff (rst)
        resp_read_data_valid |-> tag_valid)
        else $error("read data arrived with no tag at the head of the tag FIFO");

endmodule

// File: hw/conv2d_mem_if.sv
`include "conv2d_settings.svh"

module conv2d_mem_if (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        start,
    output logic                        idle,

    input  logic [31:0]                 fm_dim,
    input  logic [31:0]                 wt_offset,
    input  logic [31:0]                 ifm_offset,
    input  logic [31:0]                 ofm_offset,

    output logic [`CONV_AWIDTH-1:0]     req_read_addr,
    output logic                        req_read_addr_valid,
    input  logic                        req_read_addr_ready,

    output conv2d_pkg::elem_tag_t       tag,
    output logic                        tag_valid,
    input  logic                        tag_ready,

    input  logic [`CONV_DWIDTH-1:0]     ofm_data,
    input  logic                        ofm_valid,
    output logic                        ofm_ready,

    output conv2d_pkg::mem_wr_req_t     req_write,
    output logic                        req_write_valid,
    input  logic                        req_write_ready,

    input  logic                        resp_write_status,
    input  logic                        resp_write_status_valid,
    output logic                        resp_write_status_ready
);
    import conv2d_pkg::*;

    localparam int WT_DIM      = `CONV_WT_DIM;
    localparam int HALF_WT_DIM = WT_DIM / 2;

    localparam logic [2:0] ST_IDLE       = 3'd0;
    localparam logic [2:0] ST_READ_WT    = 3'd1;
    localparam logic [2:0] ST_READ_IFM   = 3'd2;
    localparam logic [2:0] ST_WRITE_OFM  = 3'd3;
    localparam logic [2:0] ST_LAST_WRITE = 3'd4;

    logic [2:0]         state_q;
    logic [2:0]         state_d;
    logic [31:0]        m_cnt;
    logic [31:0]        n_cnt;
    logic [31:0]        x_cnt;
    logic [31:0]        y_cnt;
    logic signed [31:0] idx;
    logic signed [31:0] idy;
    logic               halo;
    logic [31:0]        wt_idx;
    logic [31:0]        ifm_idx;
    logic [31:0]        ofm_idx;
    logic               rd_slot;
    logic               elem_step;
    logic               win_last;
    logic               ofm_fire;
    logic               last_pixel;
    mem_wr_req_t        wr_enq;
    logic               wr_enq_valid;
    logic               wr_enq_ready;
    logic               wr_fire;
    logic               status_fire;
    logic [15:0]        wr_pending;
    logic               done;

    // window coordinate of the current kernel element
    // halo when it falls outside the map on either axis
    assign idx  = $signed(x_cnt - 32'(HALF_WT_DIM) + n_cnt);
    assign idy  = $signed(y_cnt - 32'(HALF_WT_DIM) + m_cnt);
    assign halo = (idx < 0) | (idy < 0) |
                  (idx >= $signed(fm_dim)) | (idy >= $signed(fm_dim));

    assign wt_idx  = m_cnt * 32'(WT_DIM) + n_cnt;
    assign ifm_idx = $unsigned(idy) * fm_dim + $unsigned(idx);
    assign ofm_idx = y_cnt * fm_dim + x_cnt;

    assign win_last = (m_cnt == 32'(WT_DIM - 1)) & (n_cnt == 32'(WT_DIM - 1));

    // a real read only goes out together with its tag
    assign rd_slot             = (state_q == ST_READ_WT) | (state_q == ST_READ_IFM & ~halo);
    assign req_read_addr_valid = rd_slot & tag_ready;
    assign req_read_addr       = (state_q == ST_READ_WT) ? `CONV_AWIDTH'(wt_offset + wt_idx)
                                                         : `CONV_AWIDTH'(ifm_offset + ifm_idx);

    // halo cells push a tag on their own
    assign tag_valid     = (rd_slot & req_read_addr_ready) | (state_q == ST_READ_IFM & halo);
    assign tag.is_weight = state_q == ST_READ_WT;
    assign tag.halo      = (state_q == ST_READ_IFM) & halo;
    assign tag.last      = win_last;
    assign elem_step     = tag_valid & tag_ready;

    assign ofm_ready    = (state_q == ST_WRITE_OFM) & wr_enq_ready;
    assign ofm_fire     = ofm_valid & ofm_ready;
    assign last_pixel   = (x_cnt == fm_dim - 32'd1) & (y_cnt == fm_dim - 32'd1);
    assign wr_enq_valid = (state_q == ST_WRITE_OFM) & ofm_valid;
    assign wr_enq.addr  = `CONV_AWIDTH'(ofm_offset + ofm_idx);
    assign wr_enq.data  = ofm_data;

    fifo #(
        .WIDTH    ($bits(mem_wr_req_t)),
        .LOGDEPTH (`CONV_FIFO_LOGDEPTH)
    ) wr_fifo (
        .clk       (clk),
        .rst       (rst),
        .enq_valid (wr_enq_valid),
        .enq_data  (wr_enq),
        .enq_ready (wr_enq_ready),
        .deq_valid (req_write_valid),
        .deq_data  (req_write),
        .deq_ready (req_write_ready)
    );

    assign resp_write_status_ready = 1'b1;
    assign wr_fire     = req_write_valid & req_write_ready;
    assign status_fire = resp_write_status_valid & resp_write_status_ready;

    // finish on the status of the very last write once nothing else is outstanding
    assign done = (state_q == ST_LAST_WRITE) & status_fire & resp_write_status &
                  ~req_write_valid & (wr_pending == 16'd1);

    assign idle = state_q == ST_IDLE;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (start) begin
                    state_d = ST_READ_WT;
                end
            end
            ST_READ_WT, ST_READ_IFM: begin
                if (elem_step && win_last) begin
                    state_d = (state_q == ST_READ_WT) ? ST_READ_IFM : ST_WRITE_OFM;
                end
            end
            ST_WRITE_OFM: begin
                if (ofm_fire) begin
                    state_d = last_pixel ? ST_LAST_WRITE : ST_READ_IFM;
                end
            end
            ST_LAST_WRITE: begin
                if (done) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // kernel loop with n inner and m outer
    always_ff @(posedge clk) begin
        if (rst) begin
            m_cnt <= '0;
            n_cnt <= '0;
        end else if (elem_step) begin
            if (n_cnt == 32'(WT_DIM - 1)) begin
                n_cnt <= '0;
                m_cnt <= win_last ? '0 : m_cnt + 32'd1;
            end else begin
                n_cnt <= n_cnt + 32'd1;
            end
        end
    end

    // output pixel loop advances once per accepted result
    always_ff @(posedge clk) begin
        if (rst) begin
            x_cnt <= '0;
            y_cnt <= '0;
        end else if (ofm_fire) begin
            if (x_cnt == fm_dim - 32'd1) begin
                x_cnt <= '0;
                y_cnt <= last_pixel ? '0 : y_cnt + 32'd1;
            end else begin
                x_cnt <= x_cnt + 32'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_pending <= '0;
        end else begin
            case ({wr_fire, status_fire})
                2'b10:   wr_pending <= wr_pending + 16'd1;
                2'b01:   wr_pending <= wr_pending - 16'd1;
                default: wr_pending <= wr_pending;
            endcase
        end
    end

    a_rd_addr_stable: assert property (@(posedge clk) disable iff (rst)
        req_read_addr_valid && !req_read_addr_ready |=>
            req_read_addr_valid && $stable(req_read_addr))
        else $error("read address dropped or changed under back-pressure");

    // the compute unit only finishes a window while this side waits for it
    a_ofm_in_write: assert property (@(posedge clk) disable iff (rst)
        ofm_valid |-> state_q == ST_WRITE_OFM)
        else $error("ofm result outside WRITE_OFM");

endmodule

// File: hw/fifo.sv
module fifo #(
    parameter int WIDTH    = 32,
    parameter int LOGDEPTH = 4
) (
    input  logic             clk,
    input  logic             rst,

    input  logic             enq_valid,
    input  logic [WIDTH-1:0] enq_data,
    output logic             enq_ready,

    output logic             deq_valid,
    output logic [WIDTH-1:0] deq_data,
    input  logic             deq_ready
);

    localparam int DEPTH = 1 << LOGDEPTH;

    logic [WIDTH-1:0]    mem [DEPTH];
    logic [LOGDEPTH-1:0] wr_ptr;
    logic [LOGDEPTH-1:0] rd_ptr;
    logic [LOGDEPTH:0]   count;
    logic                enq_fire;
    logic                deq_fire;

    assign enq_fire  = enq_valid & enq_ready;
    assign deq_fire  = deq_valid & deq_ready;

    assign enq_ready = count != (LOGDEPTH + 1)'(DEPTH);
    assign deq_valid = count != '0;
    // head entry comes straight out of the storage registers
    assign deq_data  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (enq_fire) begin
            mem[wr_ptr] <= enq_data;
        end
    end

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (enq_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (deq_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (enq_fire && !deq_fire) begin
                count <= count + 1'b1;
            end else if (deq_fire && !enq_fire) begin
                count <= count - 1'b1;
            end
        end
    end

    // count and pointer distance drift apart on an overflow or underflow
    a_ptrs_match_count: assert property (@(posedge clk) disable iff (rst)
        count[LOGDEPTH-1:0] == LOGDEPTH'(wr_ptr - rd_ptr))
        else $error("fifo count and pointers disagree after an overflow or underflow");

endmodule

// File: hw/conv2d_pkg.sv
`include "conv2d_settings.svh"

package conv2d_pkg;

    // one element issued by the address generator
    // either a weight read, a window read or a skipped halo cell
    typedef struct packed {
        // element is a kernel weight, not a window pixel
        logic is_weight;
        // outside the map so no read went out and the value is zero
        logic halo;
        // final element of a weight load or of a window
        logic last;
    } elem_tag_t;

    // write request whose address and data share one FIFO entry
    typedef struct packed {
        logic        [`CONV_AWIDTH-1:0] addr;
        logic signed [`CONV_DWIDTH-1:0] data;
    } mem_wr_req_t;

endpackage

// File: hw/conv2d_settings.svh
`ifndef CONV2D_SETTINGS_SVH
`define CONV2D_SETTINGS_SVH

// memory word address width
`define CONV_AWIDTH 32

// signed data word width shared by weights and pixels
`define CONV_DWIDTH 32

// odd kernel side length
`define CONV_WT_DIM 3

// log2 of the tag FIFO and write FIFO depth
`define CONV_FIFO_LOGDEPTH 4

`endif
